/* dv/char_checks.svh */
`ifndef CHAR_CHECKS_SVH
`define CHAR_CHECKS_SVH

int check_count;
int err_count;

logic [7:0] shadow [0:(1 << VRAM_AW) - 1]; // Expected RAM contents

// Character ROM contents, plane 1 upper byte, plane 0 lower byte
function automatic logic [15:0] rom_word(input logic [12:0] a);
	return {a[7:0] ^ 8'hA5, a[12:5]};
endfunction

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
	end
endtask

// Expected {color, palette} for screen x on line v
function automatic logic [5:0] ref_pixel(input logic [8:0] x, input logic [8:0] v,
					 input logic flp);
	logic [9:0]  tile;
	logic [7:0]  code;
	logic [7:0]  attr;
	logic        eff_v;
	logic        eff_h;
	logic [2:0]  row;
	logic [2:0]  sel;
	logic [15:0] w;
	tile = {v[7:3], x[7:3]};
	if (flp) begin
		tile = ~tile; // Whole screen mirrored
	end
	code  = shadow[{1'b0, tile}];
	attr  = shadow[{1'b1, tile}];
	eff_v = attr[5] ^ flp;
	eff_h = attr[4] ^ flp;
	row   = v[2:0] ^ {3{eff_v}};
	w     = rom_word({attr[7:6], code, row});
	sel   = eff_h ? x[2:0] : 3'd7 - x[2:0]; // Plane bit for this pixel
	return {w[8 + sel], w[sel], attr[3:0]};
endfunction

`endif

/* dv/char_layer_tb.sv */
module char_layer_tb;
	import char_pkg::*;

	localparam int H_TOTAL  = 384;
	localparam int V_TOTAL  = 264;
	localparam int SCREEN_W = 256;
	localparam int TIMEOUT  = 3 * H_TOTAL * V_TOTAL + 20000;

	// Attribute flip bits used when filling a tile row
	localparam int FLIPS_CLEAR  = 0;
	localparam int FLIPS_SET    = 1;
	localparam int FLIPS_RANDOM = 2;

	logic               clk;
	logic               rst_n;
	logic               flip;
	logic [VRAM_AW-1:0] cpu_addr;
	logic [7:0]         cpu_din;
	logic               cpu_cs;
	logic               cpu_we;
	logic [ROM_DW-1:0]  rom_data = '0;
	logic [7:0]         cpu_dout;
	logic               cpu_wait;
	logic [ROM_AW-1:0]  rom_addr;
	logic [HCNT_W-1:0]  h_pos;
	logic [VCNT_W-1:0]  v_pos;
	logic [1:0]         pix_color;
	logic [3:0]         pix_pal;

	int cycles;
	logic [VRAM_AW-1:0] shared_addr [$]; // Written while the line is on screen

	`include "char_checks.svh"

	char_layer #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.flip      (flip),
		.cpu_addr  (cpu_addr),
		.cpu_din   (cpu_din),
		.cpu_cs    (cpu_cs),
		.cpu_we    (cpu_we),
		.rom_data  (rom_data),
		.cpu_dout  (cpu_dout),
		.cpu_wait  (cpu_wait),
		.rom_addr  (rom_addr),
		.h_pos     (h_pos),
		.v_pos     (v_pos),
		.pix_color (pix_color),
		.pix_pal   (pix_pal)
	);

	always #20 clk = ~clk;

	// External ROM, word follows the address by one cycle
	always @(posedge clk) begin
		rom_data <= rom_word(rom_addr);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout reached after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, err_count - errs_before);
		end
	endtask

	// One CPU access, held while cpu_wait is high
	task automatic cpu_access(input logic we, input logic [VRAM_AW-1:0] addr,
				  input logic [7:0] din, output logic [7:0] dout);
		int waited;
		waited = 0;
		dout   = '0;
		@(posedge clk);
		cpu_cs   <= 1'b1;
		cpu_we   <= we;
		cpu_addr <= addr;
		cpu_din  <= din;
		forever begin
			@(negedge clk);
			check("cpu_wait", cpu_wait, h_pos[2:0] >= 3'd4); // Video half of the slot
			if (!cpu_wait) begin
				break;
			end
			waited++;
			if (waited > 8) begin
				$display("CPU access to %0h never left the wait state", addr);
				err_count++;
				break;
			end
		end
		@(posedge clk); // Accepted on this edge
		cpu_cs <= 1'b0;
		cpu_we <= 1'b0;
		if (!we) begin
			@(negedge clk);
			dout = cpu_dout;
		end
	endtask

	task automatic cpu_write(input logic [VRAM_AW-1:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		cpu_access(1'b1, addr, data, unused);
		shadow[addr] = data;
	endtask

	task automatic cpu_read(input logic [VRAM_AW-1:0] addr, output logic [7:0] data);
		cpu_access(1'b0, addr, 8'h00, data);
	endtask

	task automatic fill_row(input logic [4:0] row, input int mode);
		logic [7:0] attr;
		for (int col = 0; col < 32; col++) begin
			attr = 8'($urandom);
			case (mode)
				FLIPS_CLEAR: attr[5:4] = 2'b00;
				FLIPS_SET:   attr[5:4] = 2'b11;
				default:     ;
			endcase
			cpu_write({1'b0, row, 5'(col)}, 8'($urandom));
			cpu_write({1'b1, row, 5'(col)}, attr);
		end
	endtask

	// Returns at the cycle where pixel 0 of line v is on the outputs
	task automatic wait_line_start(input logic [8:0] v);
		forever begin
			@(negedge clk);
			if (h_pos == HCNT_W'(PIX_DELAY) && v_pos == v) begin
				break;
			end
		end
	endtask

	task automatic check_line(input logic [8:0] v, input logic flp);
		logic [5:0] exp;
		wait_line_start(v);
		for (int x = 0; x < SCREEN_W; x++) begin
			exp = ref_pixel(9'(x), v, flp);
			check($sformatf("pix_color x=%0d line %0d", x, v), pix_color, exp[5:4]);
			check($sformatf("pix_pal x=%0d line %0d", x, v), pix_pal, exp[3:0]);
			if (x < SCREEN_W - 1) begin
				@(negedge clk);
			end
		end
	endtask

	task automatic reset_state_test();
		int errs;
		errs = err_count;
		@(negedge clk);
		check("h_pos after reset", h_pos, 0);
		check("v_pos after reset", v_pos, 0);
		check("rom_addr after reset", rom_addr, 0);
		check("pix_pal after reset", pix_pal, 0);
		check("pix_color after reset", pix_color, 0);
		@(negedge clk);
		check("pix_color before first load", pix_color, 0); // Shifter loads at the end of h=1
		repeat (8) begin
			@(negedge clk);
			check("cpu_wait with cpu_cs low", cpu_wait, 1'b0);
		end
		report_test("reset state", errs);
	endtask

	task automatic cpu_access_test();
		int errs;
		logic [VRAM_AW-1:0] addrs [64];
		logic [7:0] d;
		errs = err_count;
		for (int i = 0; i < 64; i++) begin
			addrs[i] = VRAM_AW'($urandom);
			repeat ($urandom_range(0, 7)) @(posedge clk); // Vary the slot phase
			cpu_write(addrs[i], 8'($urandom));
		end
		for (int i = 0; i < 64; i++) begin
			repeat ($urandom_range(0, 7)) @(posedge clk);
			cpu_read(addrs[i], d);
			check($sformatf("read back %0h", addrs[i]), d, shadow[addrs[i]]);
			@(negedge clk);
			check("cpu_dout held", cpu_dout, shadow[addrs[i]]);
		end
		report_test("cpu access", errs);
	endtask

	task automatic render_test(input string name, input int mode, input logic flp);
		int errs;
		logic [8:0] v;
		errs = err_count;
		v = 9'((int'(v_pos) + 8) % V_TOTAL); // Leaves time for the row fill
		@(posedge clk);
		flip <= flp;
		fill_row(flp ? ~v[7:3] : v[7:3], mode);
		check_line(v, flp);
		report_test(name, errs);
	endtask

	task automatic sharing_writes(input logic [8:0] v, input logic [4:0] row);
		logic [VRAM_AW-1:0] a;
		wait_line_start(v);
		repeat (24) begin
			a = VRAM_AW'($urandom);
			if (a[9:5] == row) begin
				a[9:5] = row + 5'd1; // Stay off the row on screen
			end
			repeat ($urandom_range(0, 3)) @(posedge clk);
			cpu_write(a, 8'($urandom));
			shared_addr.push_back(a);
		end
	endtask

	task automatic sharing_test();
		int errs;
		logic [8:0] v;
		logic [7:0] d;
		errs = err_count;
		v = 9'((int'(v_pos) + 8) % V_TOTAL);
		@(posedge clk);
		flip <= 1'b0;
		fill_row(v[7:3], FLIPS_RANDOM);
		shared_addr.delete();
		fork
			check_line(v, 1'b0);
			sharing_writes(v, v[7:3]);
		join
		foreach (shared_addr[i]) begin
			cpu_read(shared_addr[i], d);
			check($sformatf("shared write %0h", shared_addr[i]), d, shadow[shared_addr[i]]);
		end
		report_test("sharing", errs);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		flip     = 1'b0;
		cpu_addr = '0;
		cpu_din  = '0;
		cpu_cs   = 1'b0;
		cpu_we   = 1'b0;
		void'($urandom(86));
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		reset_state_test();
		cpu_access_test();
		render_test("plain render", FLIPS_CLEAR, 1'b0);
		render_test("tile flips", FLIPS_SET, 1'b0);
		render_test("global flip", FLIPS_RANDOM, 1'b1);
		sharing_test();

		$display("Done: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* flist.f */
+incdir+dv
hw/char_pkg.sv
hw/video_counter.sv
hw/char_vram.sv
hw/char_tile_fetch.sv
hw/char_pixel_shift.sv
hw/char_layer.sv
dv/char_layer_tb.sv

/* hw/char_layer.sv */
module char_layer #(
	parameter int H_TOTAL = 384,
	parameter int V_TOTAL = 264
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flip,
	input  logic [char_pkg::VRAM_AW-1:0] cpu_addr,
	input  logic [7:0]                   cpu_din,
	input  logic                         cpu_cs,
	input  logic                         cpu_we,
	input  logic [char_pkg::ROM_DW-1:0]  rom_data,
	output logic [7:0]                   cpu_dout,
	output logic                         cpu_wait,
	output logic [char_pkg::ROM_AW-1:0]  rom_addr,
	output logic [char_pkg::HCNT_W-1:0]  h_pos,
	output logic [char_pkg::VCNT_W-1:0]  v_pos,
	output logic [1:0]                   pix_color,
	output logic [3:0]                   pix_pal
);

	logic [7:0] vid_data;   // RAM byte for the video fetch
	logic [3:0] tile_pal;
	logic       tile_hflip;

	video_counter #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) u_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.h_pos (h_pos),
		.v_pos (v_pos)
	);

	char_vram u_vram (
		.clk      (clk),
		.rst_n    (rst_n),
		.h_pos    (h_pos),
		.v_pos    (v_pos),
		.flip     (flip),
		.cpu_addr (cpu_addr),
		.cpu_din  (cpu_din),
		.cpu_cs   (cpu_cs),
		.cpu_we   (cpu_we),
		.cpu_dout (cpu_dout),
		.cpu_wait (cpu_wait),
		.vid_data (vid_data)
	);

	char_tile_fetch u_fetch (
		.clk        (clk),
		.rst_n      (rst_n),
		.h_pos      (h_pos),
		.v_pos      (v_pos),
		.flip       (flip),
		.vid_data   (vid_data),
		.rom_addr   (rom_addr),
		.tile_pal   (tile_pal),
		.tile_hflip (tile_hflip)
	);

	// ROM sits outside, its word comes back one cycle after rom_addr
	char_pixel_shift u_shift (
		.clk        (clk),
		.rst_n      (rst_n),
		.h_pos      (h_pos),
		.rom_data   (rom_data),
		.tile_pal   (tile_pal),
		.tile_hflip (tile_hflip),
		.pix_color  (pix_color),
		.pix_pal    (pix_pal)
	);

endmodule

/* hw/char_pixel_shift.sv */
module char_pixel_shift (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [char_pkg::HCNT_W-1:0] h_pos,
	input  logic [char_pkg::ROM_DW-1:0] rom_data,
	input  logic [3:0]                  tile_pal,
	input  logic                        tile_hflip,
	output logic [1:0]                  pix_color,
	output logic [3:0]                  pix_pal
);
	import char_pkg::*;

	localparam int PW = ROM_DW / 2; // Bits per plane, one per pixel

	logic          load;
	logic [PW-1:0] pl1;
	logic [PW-1:0] pl0;
	logic          sh_hflip;
	logic [PW-1:0] src1;
	logic [PW-1:0] src0;
	logic          dir;

	assign load = (h_pos[2:0] == PH_LOAD);

	// On a load the first pixel comes straight from the ROM word
	assign src1 = load ? rom_data[ROM_DW-1:PW] : pl1;
	assign src0 = load ? rom_data[PW-1:0] : pl0;
	assign dir  = load ? tile_hflip : sh_hflip;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pl1       <= '0;
			pl0       <= '0;
			sh_hflip  <= 1'b0;
			pix_color <= '0;
			pix_pal   <= '0;
		end else begin
			if (dir) begin
				// Mirrored tile, LSB first
				pix_color <= {src1[0], src0[0]};
				pl1       <= src1 >> 1;
				pl0       <= src0 >> 1;
			end else begin
				pix_color <= {src1[PW-1], src0[PW-1]};
				pl1       <= src1 << 1;
				pl0       <= src0 << 1;
			end
			if (load) begin
				sh_hflip <= tile_hflip;
				pix_pal  <= tile_pal; // Held for all eight pixels
			end
		end
	end

	// Palette steps at the first pixel of a tile, PIX_DELAY into its fetch slot.
	// A short line may wrap right after the load
	assert property (@(posedge clk) disable iff (!rst_n)
		$changed(pix_pal) |-> (h_pos[2:0] == 3'(PIX_DELAY)) || (h_pos == '0));

endmodule

/* hw/char_pkg.sv */
package char_pkg;

	// Character RAM, 1 KB of codes followed by 1 KB of attributes
	localparam int VRAM_AW = 11;

	// Character ROM, address is {code[9:0], row[2:0]}
	localparam int ROM_AW = 13;

	// Plane 1 in the upper byte, plane 0 in the lower byte
	localparam int ROM_DW = 16;

	localparam int HCNT_W = 9;
	localparam int VCNT_W = 9;

	// Slot phase is h_pos[2:0]
	// Phases 0..3 belong to the CPU, 4..7 to the video fetch
	localparam logic [2:0] PH_CODE    = 3'd4; // Code byte address on the RAM
	localparam logic [2:0] PH_ATTR    = 3'd6; // Attribute byte address on the RAM
	localparam logic [2:0] PH_ROMADDR = 3'd0; // First phase with the new ROM address
	localparam logic [2:0] PH_LOAD    = 3'd1; // Shifter takes the ROM word

	// Cycles from the fetch count of a tile to its first pixel.
	// Tile fetched at h = 8c shows pixel 0 at h = 8c + PIX_DELAY
	localparam int PIX_DELAY = 10;

endpackage

/* hw/char_tile_fetch.sv */
module char_tile_fetch (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [char_pkg::HCNT_W-1:0] h_pos,
	input  logic [char_pkg::VCNT_W-1:0] v_pos,
	input  logic                        flip,
	input  logic [7:0]                  vid_data,
	output logic [char_pkg::ROM_AW-1:0] rom_addr,
	output logic [3:0]                  tile_pal,
	output logic                        tile_hflip
);
	import char_pkg::*;

	// RAM data lags its address by one cycle
	localparam logic [2:0] CODE_STB = PH_CODE + 3'd1;
	localparam logic [2:0] ATTR_STB = PH_ATTR + 3'd1;

	logic [2:0] phase;
	logic [7:0] code_lo;   // Code bits 7:0
	logic       eff_vflip;
	logic       eff_hflip;
	logic [2:0] row;

	assign phase = h_pos[2:0];

	// Attribute decode straight off the RAM output
	assign eff_vflip = vid_data[5] ^ flip;
	assign eff_hflip = vid_data[4] ^ flip;
	assign row       = v_pos[2:0] ^ {3{eff_vflip}}; // Mirror the row inside the tile

	always_ff @(posedge clk) begin
		if (phase == CODE_STB) begin
			code_lo <= vid_data;
		end
	end

	// Attribute byte closes the slot.
	// Address and tile controls become valid at PH_ROMADDR of the next slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rom_addr   <= '0;
			tile_pal   <= '0;
			tile_hflip <= 1'b0;
		end else if (phase == ATTR_STB) begin
			rom_addr   <= {vid_data[7:6], code_lo, row}; // Code 9:8 from attribute
			tile_pal   <= vid_data[3:0];
			tile_hflip <= eff_hflip;
		end
	end

	// ROM sees a new address only once per slot, at PH_ROMADDR
	assert property (@(posedge clk) disable iff (!rst_n)
		$changed(rom_addr) |-> phase == PH_ROMADDR);

endmodule

/* hw/char_vram.sv */
module char_vram (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [char_pkg::HCNT_W-1:0]  h_pos,
	input  logic [char_pkg::VCNT_W-1:0]  v_pos,
	input  logic                         flip,
	input  logic [char_pkg::VRAM_AW-1:0] cpu_addr,
	input  logic [7:0]                   cpu_din,
	input  logic                         cpu_cs,
	input  logic                         cpu_we,
	output logic [7:0]                   cpu_dout,
	output logic                         cpu_wait,
	output logic [7:0]                   vid_data
);
	import char_pkg::*;

	localparam int TILE_AW = VRAM_AW - 1; // Row and column bits

	logic [2:0]         phase;
	logic               vid_win;
	logic               attr_sel;
	logic [VRAM_AW-1:0] vid_addr;
	logic [VRAM_AW-1:0] ram_addr;
	logic               ram_we;
	logic               cpu_rd;
	logic               rd_pend;
	logic [7:0]         ram_q;
	logic [7:0]         dout_hold;

	logic [7:0] mem [0:(1 << VRAM_AW) - 1];

	assign phase    = h_pos[2:0];
	assign vid_win  = (phase >= PH_CODE);
	assign attr_sel = (phase >= PH_ATTR); // Upper KB holds attributes

	// Tile row from v_pos, tile column from h_pos, whole screen mirrored on flip
	assign vid_addr = {attr_sel, {TILE_AW{flip}} ^ {v_pos[7:3], h_pos[7:3]}};

	// Single port, owner chosen by the slot phase
	assign ram_addr = vid_win ? vid_addr : cpu_addr;
	assign ram_we   = cpu_cs & cpu_we & ~vid_win;
	assign cpu_rd   = cpu_cs & ~cpu_we & ~vid_win;

	assign cpu_wait = cpu_cs & vid_win; // Hold the CPU off the video half

	always_ff @(posedge clk) begin
		if (ram_we) begin
			mem[ram_addr] <= cpu_din;
		end
		ram_q <= mem[ram_addr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= cpu_rd;
		end
	end

	// Last CPU read byte, kept once the port moves on
	always_ff @(posedge clk) begin
		if (rd_pend) begin
			dout_hold <= ram_q;
		end
	end

	assign cpu_dout = rd_pend ? ram_q : dout_hold;
	assign vid_data = ram_q;

	// No CPU write lands in the video half of the slot
	assert property (@(posedge clk) disable iff (!rst_n)
		vid_win |-> !ram_we);

endmodule

/* hw/video_counter.sv */
module video_counter #(
	parameter int H_TOTAL = 384,
	parameter int V_TOTAL = 264
) (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic [char_pkg::HCNT_W-1:0] h_pos,
	output logic [char_pkg::VCNT_W-1:0] v_pos
);
	import char_pkg::*;

	localparam logic [HCNT_W-1:0] H_LAST = HCNT_W'(H_TOTAL - 1);
	localparam logic [VCNT_W-1:0] V_LAST = VCNT_W'(V_TOTAL - 1);

	logic h_wrap;
	logic v_wrap;

	assign h_wrap = (h_pos == H_LAST);
	assign v_wrap = (v_pos == V_LAST);

	// Pixel counter along the line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_pos <= '0;
		end else if (h_wrap) begin
			h_pos <= '0;
		end else begin
			h_pos <= h_pos + 1'b1;
		end
	end

	// Line counter, steps once per line on the h wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v_pos <= '0;
		end else if (h_wrap) begin
			if (v_wrap) begin
				v_pos <= '0; // End of frame
			end else begin
				v_pos <= v_pos + 1'b1;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the character layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=char_layer_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1
